// File: flist.f
+incdir+verilog
verilog/rv32i_pkg.sv
verilog/regfile.sv
verilog/control_rom.sv
verilog/instruction_decode.sv
verilog/execute.sv
verilog/decode_execute_top.sv
sim/tb_checker.sv
sim/tb_decode_execute.sv

// File: run.sh
#!/usr/bin/env bash
# build the decode/execute testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_decode_execute -f flist.f -o sim_decode_execute \
    && ./obj_dir/sim_decode_execute | tee sim.log \
    || { echo "build or run error"; exit 1; }

grep -q "^Verification passed$" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: sim/tb_checker.sv
`timescale 1ns/100ps
`include "rv32i_defs.svh"

module tb_checker import rv32i_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  rv32i_word    pc,
    input  rv32i_word    instr,
    input  ex_wb_t       ex_out,
    input  logic         drain,
    input  logic [127:0] test_name,
    output int           checks,
    output int           errors,
    output int           outstanding
);

    rv32i_word model_rf [`REG_COUNT];
    ex_wb_t    exp_q [$];
    logic      tracked_q [$];

    // branch conditions, codes 2 and 3 are the slt and sltu tests
    function automatic logic cond_true(input logic [2:0] f3, input rv32i_word x,
                                       input rv32i_word y);
        case (f3)
            3'd0: return x == y;
            3'd1: return x != y;
            3'd2, 3'd4: return $signed(x) < $signed(y);
            3'd5: return $signed(x) >= $signed(y);
            3'd3, 3'd6: return x < y;
            default: return x >= y;
        endcase
    endfunction

    // slt forms leave the adder result on alu_out
    function automatic rv32i_word alu_result(input logic [2:0] f3, input logic alt,
                                             input rv32i_word x, input rv32i_word y);
        case (f3)
            3'd0: return alt ? x - y : x + y;
            3'd1: return x << y[4:0];
            3'd4: return x ^ y;
            3'd5: return alt ? rv32i_word'($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'd6: return x | y;
            3'd7: return x & y;
            default: return x + y;
        endcase
    endfunction

    function automatic ex_wb_t predict(input rv32i_word pc_v, input rv32i_word ins);
        ex_wb_t     r;
        rv32i_word  a;
        rv32i_word  b;
        rv32i_word  imm_i;
        rv32i_word  imm_s;
        rv32i_word  imm_b;
        rv32i_word  imm_u;
        rv32i_word  imm_j;
        logic [2:0] f3;
        logic       writes;
        logic       set_less;
        a = model_rf[ins[19:15]];
        b = model_rf[ins[24:20]];
        f3 = ins[14:12];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {ins[31:12], 12'b0};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        r = '0;
        r.pc = pc_v;
        r.store_data = b;
        writes = 1'b1;
        set_less = (f3 == 3'd2 || f3 == 3'd3);
        case (ins[6:0])
            7'b0110111: r.alu_out = imm_u;
            7'b0010111: r.alu_out = pc_v + imm_u;
            7'b1101111: r.alu_out = pc_v + imm_j;
            7'b1100111: r.alu_out = (a + imm_i) & 32'hffff_fffe;
            7'b1100011:
            begin
                r.alu_out = pc_v + imm_b;
                r.br_en = cond_true(f3, a, b);
                writes = 1'b0;
            end
            7'b0000011:
            begin
                r.alu_out = a + imm_i;
                r.mem_read = 1'b1;
                writes = 1'b0;
            end
            7'b0100011:
            begin
                r.alu_out = a + imm_s;
                r.mem_write = 1'b1;
                writes = 1'b0;
            end
            7'b0010011:
            begin
                r.alu_out = alu_result(f3, f3 == 3'd5 && ins[30], a, imm_i);
                r.br_en = set_less && cond_true(f3, a, imm_i);
            end
            7'b0110011:
            begin
                r.alu_out = alu_result(f3, ins[30], a, b);
                r.br_en = set_less && cond_true(f3, a, b);
            end
            default: writes = 1'b0;
        endcase
        r.rd_data = r.alu_out;
        if (ins[6:0] == 7'b1101111 || ins[6:0] == 7'b1100111)
            r.rd_data = pc_v + 32'd4;
        if (set_less && (ins[6:0] == 7'b0010011 || ins[6:0] == 7'b0110011))
            r.rd_data = {31'b0, r.br_en};
        if (writes && ins[11:7] != 5'd0)
        begin
            r.load_regfile = 1'b1;
            r.rd = ins[11:7];
        end
        return r;
    endfunction

    // inputs change on the rising edge, so everything is stable here
    always @(negedge clk)
    begin
        ex_wb_t head;
        logic   head_tracked;
        if (rst !== 1'b0)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
                model_rf[i] = '0;
            exp_q.delete();
            tracked_q.delete();
            // both pipeline registers hold zero records after reset
            exp_q.push_back('0);
            exp_q.push_back('0);
            tracked_q.push_back(1'b0);
            tracked_q.push_back(1'b0);
            checks = 0;
            errors = 0;
            outstanding = 0;
        end
        else
        begin
            head = exp_q.pop_front();
            head_tracked = tracked_q.pop_front();
            checks++;
            if (ex_out !== head)
            begin
                errors++;
                $display("MISMATCH %0s pc %h: expected %h actual %h",
                         test_name, head.pc, head, ex_out);
            end
            if (head_tracked)
                outstanding--;
            // write-back lands now, in time for the instruction being decoded
            if (head.load_regfile && head.rd != '0)
                model_rf[head.rd] = head.rd_data;
            exp_q.push_back(predict(pc, instr));
            tracked_q.push_back(!drain);
            if (!drain)
                outstanding++;
        end
    end

endmodule

// File: sim/tb_decode_execute.sv
`timescale 1ns/100ps
`include "rv32i_defs.svh"

module tb_decode_execute import rv32i_pkg::*;
();

    logic         clk;
    logic         rst;
    rv32i_word    pc;
    rv32i_word    instr;
    ex_wb_t       ex_out;
    logic         drain;
    logic [127:0] test_name;
    int           checks;
    int           errors;
    int           outstanding;
    int           tests_run;
    logic         timed_out;

    decode_execute_top DUT (
        .clk    (clk),
        .rst    (rst),
        .pc     (pc),
        .instr  (instr),
        .ex_out (ex_out)
    );

    tb_checker u_check (
        .clk         (clk),
        .rst         (rst),
        .pc          (pc),
        .instr       (instr),
        .ex_out      (ex_out),
        .drain       (drain),
        .test_name   (test_name),
        .checks      (checks),
        .errors      (errors),
        .outstanding (outstanding)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // x0..x7 only, so results get reused often
    function automatic rv32i_reg pick_reg();
        return rv32i_reg'($urandom % 8);
    endfunction

    function automatic rv32i_word alu_instr(input rv32i_reg rd);
        logic [2:0]  f3;
        logic [11:0] imm;
        f3 = 3'($urandom);
        imm = 12'($urandom);
        if ($urandom % 2 == 0)
            return {(f3 == 3'd0 || f3 == 3'd5) ? {1'b0, 1'($urandom), 5'b0} : 7'b0,
                    pick_reg(), pick_reg(), f3, rd, 7'b0110011};
        if (f3 == 3'd1)
            imm = {7'b0, imm[4:0]};
        if (f3 == 3'd5)
            imm = {1'b0, imm[10], 5'b0, imm[4:0]};
        return {imm, pick_reg(), f3, rd, 7'b0010011};
    endfunction

    function automatic rv32i_word rand_instr(input int kind);
        rv32i_reg   rd;
        logic [2:0] f3;
        int         sel;
        rd = pick_reg();
        sel = $urandom % 6;
        f3 = (sel < 2) ? 3'(sel) : 3'(sel + 2);
        // an addi now and then keeps fresh values in the registers
        if (kind >= 2 && kind <= 4 && $urandom % 4 == 0)
            return {12'($urandom), pick_reg(), 3'b000, rd, 7'b0010011};
        case (kind)
            1: return alu_instr(rd);
            2:
            begin
                case ($urandom % 4)
                    0: return {20'($urandom), rd, 7'b0110111};
                    1: return {20'($urandom), rd, 7'b0010111};
                    2: return {20'($urandom), rd, 7'b1101111};
                    default: return {12'($urandom), pick_reg(), 3'b000, rd, 7'b1100111};
                endcase
            end
            3: return {7'($urandom), pick_reg(), pick_reg(), f3, 5'($urandom), 7'b1100011};
            4:
            begin
                if ($urandom % 2 == 0)
                    return {12'($urandom), pick_reg(), 3'b010, rd, 7'b0000011};
                return {7'($urandom), pick_reg(), pick_reg(), 3'b010, 5'($urandom),
                        7'b0100011};
            end
            5: return alu_instr(($urandom % 2 == 0) ? 5'd0 : rd);
            default: return `NOP_INSTR;
        endcase
    endfunction

    task automatic drive_nop();
        instr <= `NOP_INSTR;
        drain <= 1'b1;
    endtask

    task automatic run_test(input logic [127:0] name, input int kind, input int count);
        int err0;
        int chk0;
        int waited;
        err0 = errors;
        chk0 = checks;
        for (int i = 0; i < count; i++)
        begin
            @(posedge clk);
            test_name <= name;
            instr <= rand_instr(kind);
            drain <= 1'b0;
            if (kind != 0)
                pc <= pc + 32'd4;
        end
        @(posedge clk);
        drive_nop();
        waited = 0;
        while (outstanding != 0 && !timed_out)
        begin
            @(posedge clk);
            drive_nop();
            waited++;
            if (waited > 16)
            begin
                timed_out = 1'b1;
                $display("timeout: pipeline did not drain during test %0s", name);
            end
        end
        tests_run++;
        $display("test %0s: %0d checks, %0d errors", name, checks - chk0, errors - err0);
    endtask

    initial
    begin
        rst = 1'b1;
        pc = '0;
        instr = `NOP_INSTR;
        drain = 1'b0;
        test_name = "reset_nops";
        tests_run = 0;
        timed_out = 1'b0;
        void'($urandom(32'h227c));
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // pc stays at zero so the whole record must read zero
        run_test("reset_nops", 0, 6);
        if (!timed_out)
            run_test("alu_ops", 1, 200);
        if (!timed_out)
            run_test("upper_jump", 2, 150);
        if (!timed_out)
            run_test("branches", 3, 150);
        if (!timed_out)
            run_test("loads_stores", 4, 150);
        if (!timed_out)
            run_test("x0_writes", 5, 100);

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0 && !timed_out && checks > 0)
        begin
            $display("Verification passed");
        end
        else
        begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: verilog/control_rom.sv
`timescale 1ns/100ps

module control_rom import rv32i_pkg::*;
(
    input  rv32i_word         data,
    output rv32i_control_word ctrl,
    output alumux1_sel_t      alumux1_sel,
    output alumux2_sel_t      alumux2_sel,
    output cmpmux_sel_t       cmpmux_sel
);

    rv32i_instr_u      instr;
    rv32i_control_word cw;
    logic              writes_rd;

    assign instr = data;

    always_comb
    begin
        cw = '0;
        writes_rd = 1'b0;
        cw.opcode = rv32i_opcode'(instr.r.opcode);
        case (rv32i_opcode'(instr.r.opcode))
            op_lui:
            begin
                // rs1 index is forced to x0 in decode, so this is 0 + imm
                cw.alumux2_sel = alu2_u_imm;
                writes_rd = 1'b1;
            end
            op_auipc:
            begin
                cw.alumux1_sel = alu1_pc;
                cw.alumux2_sel = alu2_u_imm;
                writes_rd = 1'b1;
            end
            op_jal:
            begin
                cw.alumux1_sel = alu1_pc;
                cw.alumux2_sel = alu2_j_imm;
                cw.wbmux_sel = wb_pc4;
                writes_rd = 1'b1;
            end
            op_jalr:
            begin
                cw.alumux2_sel = alu2_i_imm;
                cw.wbmux_sel = wb_pc4;
                writes_rd = 1'b1;
            end
            op_br:
            begin
                cw.alumux1_sel = alu1_pc;
                cw.alumux2_sel = alu2_b_imm;
                cw.cmpop = branch_funct3_t'(instr.r.funct3);
            end
            op_load:
            begin
                cw.alumux2_sel = alu2_i_imm;
                cw.mem_read = 1'b1;
            end
            op_store:
            begin
                cw.alumux2_sel = alu2_s_imm;
                cw.mem_write = 1'b1;
            end
            op_imm:
            begin
                cw.alumux2_sel = alu2_i_imm;
                writes_rd = 1'b1;
                case (instr.i.funct3)
                    3'b010:
                    begin
                        cw.cmpop = blt;
                        cw.cmpmux_sel = cmp_i_imm;
                        cw.wbmux_sel = wb_br;
                    end
                    3'b011:
                    begin
                        cw.cmpop = bltu;
                        cw.cmpmux_sel = cmp_i_imm;
                        cw.wbmux_sel = wb_br;
                    end
                    // srai carries its flag in the immediate
                    3'b101: cw.aluop = instr.i.imm_hi[5] ? alu_sra : alu_srl;
                    default: cw.aluop = alu_ops'({1'b0, instr.i.funct3});
                endcase
            end
            op_reg:
            begin
                cw.alumux2_sel = alu2_rs2;
                writes_rd = 1'b1;
                case (instr.r.funct3)
                    3'b000: cw.aluop = instr.r.funct7[5] ? alu_sub : alu_add;
                    3'b010:
                    begin
                        cw.cmpop = blt;
                        cw.wbmux_sel = wb_br;
                    end
                    3'b011:
                    begin
                        cw.cmpop = bltu;
                        cw.wbmux_sel = wb_br;
                    end
                    3'b101: cw.aluop = instr.r.funct7[5] ? alu_sra : alu_srl;
                    default: cw.aluop = alu_ops'({1'b0, instr.r.funct3});
                endcase
            end
            default: cw = '0;
        endcase
        // writes to x0 are dropped here already
        cw.load_regfile = writes_rd && (instr.r.rd != '0);
        cw.rd = cw.load_regfile ? instr.r.rd : '0;
    end

    assign ctrl = cw;
    assign alumux1_sel = cw.alumux1_sel;
    assign alumux2_sel = cw.alumux2_sel;
    assign cmpmux_sel = cw.cmpmux_sel;

    always_comb
    begin
        a_mem_excl: assert (!(cw.mem_read && cw.mem_write))
            else $error("control word requests read and write together");
    end

endmodule

// File: verilog/decode_execute_top.sv
`timescale 1ns/100ps

module decode_execute_top import rv32i_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  rv32i_word pc,
    input  rv32i_word instr,
    output ex_wb_t    ex_out
);

    id_ex_t id_ex;

    // write-back returns straight from the EX/WB record
    instruction_decode u_decode (
        .clk          (clk),
        .rst          (rst),
        .pc           (pc),
        .instr        (instr),
        .rd           (ex_out.rd),
        .rd_in        (ex_out.rd_data),
        .load_regfile (ex_out.load_regfile),
        .id_ex        (id_ex)
    );

    execute u_execute (
        .clk    (clk),
        .rst    (rst),
        .id_ex  (id_ex),
        .ex_out (ex_out)
    );

endmodule

// File: verilog/execute.sv
`timescale 1ns/100ps

module execute import rv32i_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  id_ex_t id_ex,
    output ex_wb_t ex_out
);

    rv32i_word alu_res;
    rv32i_word target;
    rv32i_word rd_data;
    logic      cmp_out;
    logic      br_en;
    ex_wb_t    ex_next;

    always_comb
    begin
        case (id_ex.ctrl.aluop)
            alu_sll: alu_res = id_ex.alu_in1 << id_ex.alu_in2[4:0];
            alu_sra: alu_res = $signed(id_ex.alu_in1) >>> id_ex.alu_in2[4:0];
            alu_sub: alu_res = id_ex.alu_in1 - id_ex.alu_in2;
            alu_xor: alu_res = id_ex.alu_in1 ^ id_ex.alu_in2;
            alu_srl: alu_res = id_ex.alu_in1 >> id_ex.alu_in2[4:0];
            alu_or:  alu_res = id_ex.alu_in1 | id_ex.alu_in2;
            alu_and: alu_res = id_ex.alu_in1 & id_ex.alu_in2;
            default: alu_res = id_ex.alu_in1 + id_ex.alu_in2;
        endcase
    end

    always_comb
    begin
        case (id_ex.ctrl.cmpop)
            beq:     cmp_out = (id_ex.rs1_val == id_ex.cmp_in);
            bne:     cmp_out = (id_ex.rs1_val != id_ex.cmp_in);
            blt:     cmp_out = ($signed(id_ex.rs1_val) < $signed(id_ex.cmp_in));
            bge:     cmp_out = ($signed(id_ex.rs1_val) >= $signed(id_ex.cmp_in));
            bltu:    cmp_out = (id_ex.rs1_val < id_ex.cmp_in);
            bgeu:    cmp_out = (id_ex.rs1_val >= id_ex.cmp_in);
            default: cmp_out = 1'b0;
        endcase
    end

    // comparator result only counts for branches and slt forms
    assign br_en = cmp_out &&
        (id_ex.ctrl.opcode == op_br || id_ex.ctrl.wbmux_sel == wb_br);

    assign target = (id_ex.ctrl.opcode == op_jalr) ? {alu_res[31:1], 1'b0} : alu_res;

    always_comb
    begin
        case (id_ex.ctrl.wbmux_sel)
            wb_br:   rd_data = {31'b0, br_en};
            wb_pc4:  rd_data = id_ex.pc + 32'd4;
            default: rd_data = target;
        endcase
    end

    always_comb
    begin
        ex_next.pc = id_ex.pc;
        ex_next.alu_out = target;
        ex_next.br_en = br_en;
        ex_next.rd = id_ex.ctrl.rd;
        ex_next.rd_data = rd_data;
        ex_next.load_regfile = id_ex.ctrl.load_regfile;
        ex_next.mem_read = id_ex.ctrl.mem_read;
        ex_next.mem_write = id_ex.ctrl.mem_write;
        ex_next.store_data = id_ex.rs2_val;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            ex_out <= '0;
        else
            ex_out <= ex_next;
    end

    a_no_bad_write: assert property (@(posedge clk) disable iff (rst)
        ex_out.load_regfile |-> (ex_out.rd != '0 && !ex_out.mem_write));

    a_branch_no_write: assert property (@(posedge clk) disable iff (rst)
        (id_ex.ctrl.opcode == op_br) |-> !id_ex.ctrl.load_regfile);

endmodule

// File: verilog/instruction_decode.sv
`timescale 1ns/100ps

module instruction_decode import rv32i_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  rv32i_word pc,
    input  rv32i_word instr,
    // write-back port
    input  rv32i_reg  rd,
    input  rv32i_word rd_in,
    input  logic      load_regfile,
    output id_ex_t    id_ex
);

    rv32i_word i_imm;
    rv32i_word s_imm;
    rv32i_word b_imm;
    rv32i_word u_imm;
    rv32i_word j_imm;

    rv32i_control_word ctrl;
    alumux1_sel_t      alumux1_sel;
    alumux2_sel_t      alumux2_sel;
    cmpmux_sel_t       cmpmux_sel;

    rv32i_reg  rs1_idx;
    rv32i_word reg_a;
    rv32i_word reg_b;
    rv32i_word alu_in1;
    rv32i_word alu_in2;
    rv32i_word cmp_in;
    id_ex_t    id_ex_next;

    assign i_imm = {{21{instr[31]}}, instr[30:20]};
    assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'h000};
    assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    control_rom u_control_rom (
        .data        (instr),
        .ctrl        (ctrl),
        .alumux1_sel (alumux1_sel),
        .alumux2_sel (alumux2_sel),
        .cmpmux_sel  (cmpmux_sel)
    );

    // lui has immediate bits where rs1 sits, read x0 instead
    assign rs1_idx = (ctrl.opcode == op_lui) ? '0 : instr[19:15];

    regfile u_regfile (
        .clk   (clk),
        .rst   (rst),
        .load  (load_regfile),
        .in    (rd_in),
        .src_a (rs1_idx),
        .src_b (instr[24:20]),
        .dest  (rd),
        .reg_a (reg_a),
        .reg_b (reg_b)
    );

    always_comb
    begin
        alu_in1 = (alumux1_sel == alu1_pc) ? pc : reg_a;

        case (alumux2_sel)
            alu2_i_imm: alu_in2 = i_imm;
            alu2_u_imm: alu_in2 = u_imm;
            alu2_b_imm: alu_in2 = b_imm;
            alu2_s_imm: alu_in2 = s_imm;
            alu2_j_imm: alu_in2 = j_imm;
            default:    alu_in2 = reg_b;
        endcase

        cmp_in = (cmpmux_sel == cmp_i_imm) ? i_imm : reg_b;
    end

    always_comb
    begin
        id_ex_next.pc = pc;
        id_ex_next.instruction = instr;
        id_ex_next.ctrl = ctrl;
        id_ex_next.alu_in1 = alu_in1;
        id_ex_next.alu_in2 = alu_in2;
        id_ex_next.cmp_in = cmp_in;
        id_ex_next.rs1_val = reg_a;
        id_ex_next.rs2_val = reg_b;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            id_ex <= '0;
        else
            id_ex <= id_ex_next;
    end

endmodule

// File: verilog/regfile.sv
`timescale 1ns/100ps
`include "rv32i_defs.svh"

module regfile import rv32i_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      load,
    input  rv32i_word in,
    input  rv32i_reg  src_a,
    input  rv32i_reg  src_b,
    input  rv32i_reg  dest,
    output rv32i_word reg_a,
    output rv32i_word reg_b
);

    rv32i_word mem [`REG_COUNT];
    logic      wr_en;

    // x0 is never written
    assign wr_en = load && (dest != '0);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
                mem[i] <= '0;
        end
        else if (wr_en)
        begin
            mem[dest] <= in;
        end
    end

    // write-through so a same-cycle reader sees the new value
    assign reg_a = (wr_en && dest == src_a) ? in : mem[src_a];
    assign reg_b = (wr_en && dest == src_b) ? in : mem[src_b];

    a_x0_reads_zero: assert property (@(posedge clk) disable iff (rst)
        (src_a != '0 || reg_a == '0) && (src_b != '0 || reg_b == '0));

endmodule

// File: verilog/rv32i_defs.svh
`ifndef RV32I_DEFS_SVH
`define RV32I_DEFS_SVH

// machine word, fixed by the ISA
`define XLEN 32

// architectural integer registers
`define REG_COUNT 32

// bits needed to name one register
`define REG_ADDR_W 5

// addi x0, x0, 0
// the fetch side sends this in idle slots
`define NOP_INSTR 32'h0000_0013

`endif

// File: verilog/rv32i_pkg.sv
`include "rv32i_defs.svh"

package rv32i_pkg;

    typedef logic [`XLEN-1:0] rv32i_word;
    typedef logic [`REG_ADDR_W-1:0] rv32i_reg;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode;

    // top bit is instr[30], low bits are funct3
    typedef enum logic [3:0] {
        alu_add = 4'b0000,
        alu_sll = 4'b0001,
        alu_xor = 4'b0100,
        alu_srl = 4'b0101,
        alu_or  = 4'b0110,
        alu_and = 4'b0111,
        alu_sub = 4'b1000,
        alu_sra = 4'b1101
    } alu_ops;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic {
        alu1_rs1 = 1'b0,
        alu1_pc  = 1'b1
    } alumux1_sel_t;

    typedef enum logic [2:0] {
        alu2_i_imm = 3'd0,
        alu2_u_imm = 3'd1,
        alu2_b_imm = 3'd2,
        alu2_s_imm = 3'd3,
        alu2_j_imm = 3'd4,
        alu2_rs2   = 3'd5
    } alumux2_sel_t;

    // i immediate only for slti/sltiu
    typedef enum logic {
        cmp_rs2   = 1'b0,
        cmp_i_imm = 1'b1
    } cmpmux_sel_t;

    typedef enum logic [1:0] {
        wb_alu = 2'd0,
        wb_br  = 2'd1,
        wb_pc4 = 2'd2
    } wbmux_sel_t;

    typedef struct packed {
        rv32i_opcode    opcode;
        alu_ops         aluop;
        branch_funct3_t cmpop;
        alumux1_sel_t   alumux1_sel;
        alumux2_sel_t   alumux2_sel;
        cmpmux_sel_t    cmpmux_sel;
        wbmux_sel_t     wbmux_sel;
        logic           load_regfile;
        logic           mem_read;
        logic           mem_write;
        rv32i_reg       rd;
    } rv32i_control_word;

    typedef struct packed {
        logic [6:0] funct7;
        rv32i_reg   rs2;
        rv32i_reg   rs1;
        logic [2:0] funct3;
        rv32i_reg   rd;
        logic [6:0] opcode;
    } r_fields_t;

    // I and S share this split, rs2_imm is rs2 or imm[4:0]
    typedef struct packed {
        logic [6:0] imm_hi;
        rv32i_reg   rs2_imm;
        rv32i_reg   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } is_fields_t;

    typedef union packed {
        r_fields_t  r;
        is_fields_t i;
    } rv32i_instr_u;

    typedef struct packed {
        rv32i_word         pc;
        rv32i_word         instruction;
        rv32i_control_word ctrl;
        rv32i_word         alu_in1;
        rv32i_word         alu_in2;
        rv32i_word         cmp_in;
        rv32i_word         rs1_val;
        rv32i_word         rs2_val;
    } id_ex_t;

    typedef struct packed {
        rv32i_word pc;
        rv32i_word alu_out;
        logic      br_en;
        rv32i_reg  rd;
        rv32i_word rd_data;
        logic      load_regfile;
        logic      mem_read;
        logic      mem_write;
        rv32i_word store_data;
    } ex_wb_t;

endpackage
